//--- Makefile
# Verilator build and run of the packet switch testbench

VERILATOR ?= verilator
TOP       ?= tb_switch
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hw/switch_pkg.sv
hw/port_wr_frontend.sv
hw/packet_bank.sv
hw/join_order.sv
hw/port_queue.sv
hw/port_rd_frontend.sv
hw/switch_top.sv
testbench/tb_switch.sv

//--- hw/join_order.sv
`timescale 1ns/100ps

module join_order import switch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pkt_desc_t [N_PORTS-1:0] in_desc,
    input  logic [N_PORTS-1:0]      in_vld,
    output pkt_desc_t               out_desc,
    output logic                    out_vld
);

    // one entry per completion cycle, all strobes of that cycle together
    logic [N_PORTS-1:0]          vld_mem  [JOIN_DEPTH];
    pkt_desc_t [N_PORTS-1:0]     desc_mem [JOIN_DEPTH];
    logic [$clog2(JOIN_DEPTH):0] wr_ptr;
    logic [$clog2(JOIN_DEPTH):0] rd_ptr;
    logic [$clog2(JOIN_DEPTH):0] fill;
    logic                        empty;
    logic                        full;

    logic [N_PORTS-1:0] served;
    logic [N_PORTS-1:0] pending;
    port_idx_t          pick;
    logic               last_bit;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (fill == 0);
    assign full  = (fill == JOIN_DEPTH);

    // lowest bank of the head bundle not yet sent
    always_comb begin
        pending = vld_mem[rd_ptr[$clog2(JOIN_DEPTH)-1:0]] & ~served;
        pick    = '0;
        for (int i = N_PORTS - 1; i >= 0; i--) begin
            if (pending[i])
                pick = port_idx_t'(i);
        end
        last_bit = (pending & ~(N_PORTS'(1) << pick)) == '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            served  <= '0;
            out_vld <= 1'b0;
        end else begin
            out_vld <= !empty;
            if (in_vld != '0)
                wr_ptr <= wr_ptr + 1'b1;
            if (!empty) begin
                if (last_bit) begin
                    rd_ptr <= rd_ptr + 1'b1;
                    served <= '0;
                end else begin
                    served[pick] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld != '0) begin
            vld_mem[wr_ptr[$clog2(JOIN_DEPTH)-1:0]]  <= in_vld;
            desc_mem[wr_ptr[$clog2(JOIN_DEPTH)-1:0]] <= in_desc;
        end
        if (!empty)
            out_desc <= desc_mem[rd_ptr[$clog2(JOIN_DEPTH)-1:0]][pick];
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_vld != '0 |-> !full);

endmodule

//--- hw/packet_bank.sv
`timescale 1ns/100ps

module packet_bank import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wr_word_t              bank_wr,
    output page_t                 alloc_page,
    output logic                  pause,
    output count_t                free_count,
    input  rd_req_t [N_PORTS-1:0] rd_req,
    output bank_rd_t              rd_out
);

    word_t              mem [N_PAGES*PAGE_WORDS];
    logic [N_PAGES-1:0] free_map;
    page_t              wr_page;
    page_t              wr_addr_page;

    logic [N_PORTS-1:0] req_vld;
    logic [N_PORTS-1:0] req_open;
    logic [N_PORTS-1:0] fair_mask;
    port_idx_t          gnt;
    logic               busy;
    page_t              rd_page;
    len_t               rd_len;
    offset_t            rd_offset;
    logic               last_word;

    // lowest free page goes to the next packet
    always_comb begin
        alloc_page = '0;
        free_count = '0;
        for (int i = N_PAGES - 1; i >= 0; i--) begin
            if (free_map[i])
                alloc_page = page_t'(i);
            free_count = free_count + count_t'(free_map[i]);
        end
    end

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    assign wr_addr_page = bank_wr.first ? alloc_page : wr_page;

    always_ff @(posedge clk) begin
        if (bank_wr.vld) begin
            mem[{wr_addr_page, bank_wr.offset}] <= bank_wr.data;
            if (bank_wr.first)
                wr_page <= alloc_page;
        end
    end

    // ----------------------------------------------------------------------
    // read arbitration and burst
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < N_PORTS; i++)
            req_vld[i] = rd_req[i].vld;
        req_open = req_vld & fair_mask;
        gnt = '0;
        for (int i = N_PORTS - 1; i >= 0; i--) begin
            if (req_open[i])
                gnt = port_idx_t'(i);
        end
    end

    assign last_word = (len_t'(rd_offset) + 1'b1) == rd_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map   <= '1;
            fair_mask  <= '1;
            busy       <= 1'b0;
            pause      <= 1'b0;
            rd_out.vld <= 1'b0;
        end else begin
            pause      <= (free_count == 0);
            rd_out.vld <= busy;
            if (bank_wr.vld && bank_wr.first)
                free_map[alloc_page] <= 1'b0;
            // page returns to the pool after its last word went out
            if (rd_out.vld && rd_out.last)
                free_map[rd_page] <= 1'b1;
            if (busy) begin
                if (last_word)
                    busy <= 1'b0;
            end else if (req_open != '0) begin
                busy           <= 1'b1;
                fair_mask[gnt] <= 1'b0;
            end else begin
                // every waiting port has been served once
                fair_mask <= '1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            rd_offset   <= rd_offset + 1'b1;
            rd_out.data <= mem[{rd_page, rd_offset}];
            rd_out.last <= last_word;
        end else if (req_open != '0) begin
            rd_offset   <= '0;
            rd_page     <= rd_req[gnt].page;
            rd_len      <= rd_req[gnt].len;
            rd_out.port <= gnt;
        end
    end

    a_release_used_page: assert property (@(posedge clk) disable iff (!rst_n)
        rd_out.vld && rd_out.last |-> !free_map[rd_page]);

    a_alloc_with_space: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.vld && bank_wr.first |-> free_count != 0);

endmodule

//--- hw/port_queue.sv
`timescale 1ns/100ps

module port_queue import switch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pkt_desc_t in_desc,
    input  logic      in_vld,
    output pkt_desc_t head,
    output logic      head_vld,
    input  logic      pop,
    input  port_idx_t port_id
);

    pkt_desc_t                    mem [N_PRIORS][QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH):0] wr_ptr [N_PRIORS];
    logic [$clog2(QUEUE_DEPTH):0] rd_ptr [N_PRIORS];
    logic [N_PRIORS-1:0]          nonempty;
    prior_t                       sel;
    logic                         push;

    assign push = in_vld && (in_desc.dest == port_id);

    // strict priority, highest non-empty queue wins
    always_comb begin
        sel = '0;
        for (int p = 0; p < N_PRIORS; p++) begin
            nonempty[p] = (wr_ptr[p] != rd_ptr[p]);
            if (nonempty[p])
                sel = prior_t'(p);
        end
    end

    assign head_vld = |nonempty;
    assign head     = mem[sel][rd_ptr[sel][$clog2(QUEUE_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < N_PRIORS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
            end
        end else begin
            if (push)
                wr_ptr[in_desc.prior] <= wr_ptr[in_desc.prior] + 1'b1;
            if (pop)
                rd_ptr[sel] <= rd_ptr[sel] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[in_desc.prior][wr_ptr[in_desc.prior][$clog2(QUEUE_DEPTH)-1:0]] <= in_desc;
    end

endmodule

//--- hw/port_rd_frontend.sv
`timescale 1ns/100ps

module port_rd_frontend import switch_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  pkt_desc_t              head,
    input  logic                   head_vld,
    output logic                   pop,
    output rd_req_t [N_PORTS-1:0]  rd_req,
    input  bank_rd_t [N_PORTS-1:0] bank_rd,
    input  port_idx_t              port_id,
    output logic                   rd_sop,
    output logic                   rd_eop,
    output logic                   rd_vld,
    output word_t                  rd_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_STREAM
    } state_t;

    state_t    state;
    port_idx_t cur_bank;
    page_t     cur_page;
    len_t      cur_len;
    bank_rd_t  src;
    logic      hit;

    // ready only matters when a new packet would start
    assign pop = (state == S_IDLE) && ready && head_vld;
    assign src = bank_rd[cur_bank];
    assign hit = (state != S_IDLE) && src.vld && (src.port == port_id);

    always_comb begin
        for (int b = 0; b < N_PORTS; b++) begin
            rd_req[b].vld  = (state == S_REQ) && (cur_bank == port_idx_t'(b));
            rd_req[b].page = cur_page;
            rd_req[b].len  = cur_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= hit;
            rd_sop <= hit && (state == S_REQ);
            rd_eop <= hit && src.last;
            case (state)
                S_IDLE: begin
                    if (pop)
                        state <= S_REQ;
                end
                // first word of the grant ends the request
                S_REQ: begin
                    if (hit)
                        state <= src.last ? S_IDLE : S_STREAM;
                end
                S_STREAM: begin
                    if (hit && src.last)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_bank <= head.bank;
            cur_page <= head.page;
            cur_len  <= head.len;
        end
        if (hit)
            rd_data <= src.data;
    end

    a_burst_gapless: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld && !rd_eop |=> rd_vld);

endmodule

//--- hw/port_wr_frontend.sv
`timescale 1ns/100ps

module port_wr_frontend import switch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_sop,
    input  logic      wr_eop,
    input  logic      wr_vld,
    input  word_t     wr_data,
    input  page_t     alloc_page,
    output wr_word_t  bank_wr,
    output pkt_desc_t desc,
    output logic      desc_vld,
    input  port_idx_t bank
);

    logic      pkt_open;
    offset_t   next_offset;
    offset_t   word_offset;
    port_idx_t dest_q;
    prior_t    prior_q;
    len_t      len_q;
    logic      eop_q;
    page_t     page_q;
    page_t     cur_page;

    // sop always restarts the word index
    assign word_offset = wr_sop ? offset_t'(0) : next_offset;

    // ----------------------------------------------------------------------
    // input register stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_open    <= 1'b0;
            next_offset <= '0;
            eop_q       <= 1'b0;
            bank_wr.vld <= 1'b0;
            desc_vld    <= 1'b0;
        end else begin
            bank_wr.vld <= wr_vld;
            eop_q       <= wr_vld && wr_eop;
            desc_vld    <= bank_wr.vld && eop_q;
            if (wr_vld) begin
                next_offset <= word_offset + 1'b1;
                pkt_open    <= !wr_eop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            bank_wr.first  <= wr_sop;
            bank_wr.offset <= word_offset;
            bank_wr.data   <= wr_data;
        end
        // header word carries dest in 1:0 and priority in 3:2
        if (wr_vld && wr_sop) begin
            dest_q  <= wr_data[1:0];
            prior_q <= wr_data[3:2];
        end
        if (wr_vld && wr_eop)
            len_q <= len_t'(word_offset) + 1'b1;
    end

    // ----------------------------------------------------------------------
    // descriptor stage
    // ----------------------------------------------------------------------
    // a one word packet takes its page in the same cycle it is written
    assign cur_page = bank_wr.first ? alloc_page : page_q;

    always_ff @(posedge clk) begin
        if (bank_wr.vld && bank_wr.first)
            page_q <= alloc_page;
        if (bank_wr.vld && eop_q)
            desc <= '{bank: bank, page: cur_page, dest: dest_q, prior: prior_q, len: len_q};
    end

    a_word_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && !wr_sop |-> pkt_open);

endmodule

//--- hw/switch_pkg.sv
package switch_pkg;

    // ----------------------------------------------------------------------
    // switch dimensions
    // ----------------------------------------------------------------------
    localparam int N_PORTS     = 4;
    localparam int N_PAGES     = 8;
    localparam int PAGE_WORDS  = 8;
    localparam int N_PRIORS    = 4;
    localparam int QUEUE_DEPTH = 32;
    localparam int JOIN_DEPTH  = 32;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  port_idx_t;
    typedef logic [1:0]  prior_t;
    typedef logic [2:0]  page_t;
    typedef logic [2:0]  offset_t;
    typedef logic [3:0]  len_t;
    typedef logic [3:0]  count_t;

    // ----------------------------------------------------------------------
    // bundles passed between blocks
    // ----------------------------------------------------------------------
    // where a stored packet lives and where it goes
    typedef struct packed {
        port_idx_t bank;
        page_t     page;
        port_idx_t dest;
        prior_t    prior;
        len_t      len;
    } pkt_desc_t;

    // one word written into a bank
    typedef struct packed {
        logic    vld;
        logic    first;
        offset_t offset;
        word_t   data;
    } wr_word_t;

    // read request from an output port to one bank
    typedef struct packed {
        logic  vld;
        page_t page;
        len_t  len;
    } rd_req_t;

    // bank read stream, seen by every output port
    typedef struct packed {
        logic      vld;
        port_idx_t port;
        word_t     data;
        logic      last;
    } bank_rd_t;

endpackage

//--- hw/switch_top.sv
`timescale 1ns/100ps

module switch_top import switch_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [N_PORTS-1:0]  wr_sop,
    input  logic [N_PORTS-1:0]  wr_eop,
    input  logic [N_PORTS-1:0]  wr_vld,
    input  word_t [N_PORTS-1:0] wr_data,
    input  logic [N_PORTS-1:0]  ready,
    output logic [N_PORTS-1:0]  pause,
    output logic                full,
    output logic                almost_full,
    output logic [N_PORTS-1:0]  rd_sop,
    output logic [N_PORTS-1:0]  rd_eop,
    output logic [N_PORTS-1:0]  rd_vld,
    output word_t [N_PORTS-1:0] rd_data
);

    wr_word_t  [N_PORTS-1:0] bank_wr;
    page_t     [N_PORTS-1:0] alloc_page;
    pkt_desc_t [N_PORTS-1:0] wr_desc;
    logic      [N_PORTS-1:0] wr_desc_vld;
    count_t    [N_PORTS-1:0] free_count;
    bank_rd_t  [N_PORTS-1:0] bank_rd;
    pkt_desc_t               join_desc;
    logic                    join_vld;
    pkt_desc_t [N_PORTS-1:0] head;
    logic      [N_PORTS-1:0] head_vld;
    logic      [N_PORTS-1:0] pop;
    logic                    all_empty;
    logic                    all_half;

    // read requests indexed [port][bank] and transposed to [bank][port]
    rd_req_t [N_PORTS-1:0][N_PORTS-1:0] req_by_port;
    rd_req_t [N_PORTS-1:0][N_PORTS-1:0] req_by_bank;

    // ----------------------------------------------------------------------
    // per port slices
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < N_PORTS; i++) begin : g_port
        port_wr_frontend i_wr (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_sop     (wr_sop[i]),
            .wr_eop     (wr_eop[i]),
            .wr_vld     (wr_vld[i]),
            .wr_data    (wr_data[i]),
            .alloc_page (alloc_page[i]),
            .bank_wr    (bank_wr[i]),
            .desc       (wr_desc[i]),
            .desc_vld   (wr_desc_vld[i]),
            .bank       (port_idx_t'(i))
        );

        packet_bank i_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .bank_wr    (bank_wr[i]),
            .alloc_page (alloc_page[i]),
            .pause      (pause[i]),
            .free_count (free_count[i]),
            .rd_req     (req_by_bank[i]),
            .rd_out     (bank_rd[i])
        );

        port_queue i_queue (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_desc  (join_desc),
            .in_vld   (join_vld),
            .head     (head[i]),
            .head_vld (head_vld[i]),
            .pop      (pop[i]),
            .port_id  (port_idx_t'(i))
        );

        port_rd_frontend i_rd (
            .clk      (clk),
            .rst_n    (rst_n),
            .ready    (ready[i]),
            .head     (head[i]),
            .head_vld (head_vld[i]),
            .pop      (pop[i]),
            .rd_req   (req_by_port[i]),
            .bank_rd  (bank_rd),
            .port_id  (port_idx_t'(i)),
            .rd_sop   (rd_sop[i]),
            .rd_eop   (rd_eop[i]),
            .rd_vld   (rd_vld[i]),
            .rd_data  (rd_data[i])
        );

        for (genvar j = 0; j < N_PORTS; j++) begin : g_xbar
            assign req_by_bank[i][j] = req_by_port[j][i];
        end
    end

    join_order i_join (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_desc  (wr_desc),
        .in_vld   (wr_desc_vld),
        .out_desc (join_desc),
        .out_vld  (join_vld)
    );

    // ----------------------------------------------------------------------
    // buffer fill flags
    // ----------------------------------------------------------------------
    always_comb begin
        all_empty = 1'b1;
        all_half  = 1'b1;
        for (int i = 0; i < N_PORTS; i++) begin
            if (free_count[i] != 0)
                all_empty = 1'b0;
            if (free_count[i] > count_t'(N_PAGES / 2))
                all_half = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full        <= all_empty;
            almost_full <= all_half;
        end
    end

endmodule

//--- testbench/tb_switch.sv
`timescale 1ns/100ps

module tb_switch import switch_pkg::*; ();

    typedef struct packed {
        port_idx_t dest;
        prior_t    prior;
        len_t      len;
    } pkt_spec_t;

    logic                clk;
    logic                rst_n;
    logic [N_PORTS-1:0]  wr_sop;
    logic [N_PORTS-1:0]  wr_eop;
    logic [N_PORTS-1:0]  wr_vld;
    word_t [N_PORTS-1:0] wr_data;
    logic [N_PORTS-1:0]  ready;
    logic [N_PORTS-1:0]  pause;
    logic                full;
    logic                almost_full;
    logic [N_PORTS-1:0]  rd_sop;
    logic [N_PORTS-1:0]  rd_eop;
    logic [N_PORTS-1:0]  rd_vld;
    word_t [N_PORTS-1:0] rd_data;

    integer seed;
    int     errors;
    int     timeouts;

    // traffic source state, one slot per input port
    pkt_spec_t spec_q [N_PORTS][$];
    word_t     pkt_words [N_PORTS][PAGE_WORDS];
    int        pkt_len [N_PORTS];
    int        word_pos [N_PORTS];
    int        words_left [N_PORTS];
    int        gap_left [N_PORTS];
    int        started [N_PORTS];
    int        sop_age [N_PORTS];
    int        half_age;
    int        full_age;
    logic      fill_phase;

    // reference model, indexed by dest * N_PRIORS + prior
    word_t exp_words [N_PORTS*N_PRIORS][$];
    int    exp_lens [N_PORTS*N_PRIORS][$];

    // output monitor state
    logic [N_PORTS-1:0] in_burst;
    word_t              got_words [N_PORTS][PAGE_WORDS];
    int                 got_count [N_PORTS];
    prior_t             prior_log [$];

    switch_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .ready       (ready),
        .pause       (pause),
        .full        (full),
        .almost_full (almost_full),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

    always #20 clk = ~clk;

    // ----------------------------------------------------------------------
    // reporting
    // ----------------------------------------------------------------------
    task automatic log_error(string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic log_timeout(string what);
        timeouts++;
        $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    // ----------------------------------------------------------------------
    // traffic sources
    // ----------------------------------------------------------------------
    function automatic pkt_spec_t random_spec();
        pkt_spec_t s;
        s.dest  = port_idx_t'($random(seed));
        s.prior = prior_t'($random(seed));
        s.len   = len_t'(1 + ($random(seed) & 7));
        return s;
    endfunction

    function automatic logic traffic_done();
        logic done;
        done = 1'b1;
        for (int p = 0; p < N_PORTS; p++) begin
            if (spec_q[p].size() != 0 || words_left[p] != 0)
                done = 1'b0;
        end
        return done;
    endfunction

    task automatic clear_inputs();
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
    endtask

    task automatic build_packet(int p, pkt_spec_t s);
        word_t hdr;
        hdr            = word_t'($random(seed));
        hdr[1:0]       = s.dest;
        hdr[3:2]       = s.prior;
        pkt_words[p][0] = hdr;
        for (int i = 1; i < PAGE_WORDS; i++)
            pkt_words[p][i] = word_t'($random(seed));
        pkt_len[p]    = int'(s.len);
        word_pos[p]   = 0;
        words_left[p] = int'(s.len);
    endtask

    task automatic push_model(int p);
        int idx;
        idx = int'(pkt_words[p][0][1:0]) * N_PRIORS + int'(pkt_words[p][0][3:2]);
        exp_lens[idx].push_back(pkt_len[p]);
        for (int i = 0; i < pkt_len[p]; i++)
            exp_words[idx].push_back(pkt_words[p][i]);
    endtask

    task automatic send_word(int p);
        wr_vld[p]  = 1'b1;
        wr_sop[p]  = (word_pos[p] == 0);
        wr_eop[p]  = (words_left[p] == 1);
        wr_data[p] = pkt_words[p][word_pos[p]];
        word_pos[p]++;
        words_left[p]--;
        // two idle cycles at least, so pause has caught up before the next sop
        if (words_left[p] == 0) begin
            push_model(p);
            gap_left[p] = 2 + ($random(seed) & 1);
        end
    endtask

    // one falling edge worth of input activity; lower ports push to the model first
    task automatic drive_cycle();
        for (int p = 0; p < N_PORTS; p++) begin
            wr_vld[p] = 1'b0;
            wr_sop[p] = 1'b0;
            wr_eop[p] = 1'b0;
            if (words_left[p] > 0) begin
                if (($random(seed) & 3) != 0)
                    send_word(p);
            end else if (gap_left[p] > 0) begin
                gap_left[p]--;
            end else if (spec_q[p].size() != 0 && !pause[p]) begin
                build_packet(p, spec_q[p].pop_front());
                started[p]++;
                send_word(p);
            end
        end
    endtask

    // with no reads, the flags follow from the number of packets started
    task automatic check_fill_flags();
        int min_started;
        min_started = N_PAGES;
        for (int p = 0; p < N_PORTS; p++) begin
            if (started[p] < N_PAGES) begin
                assert (!pause[p])
                    else log_error($sformatf("pause %0d high after %0d packets", p, started[p]));
            end else begin
                sop_age[p]++;
                assert (pause[p] || sop_age[p] <= 3)
                    else log_error($sformatf("pause %0d still low with bank full", p));
            end
            if (started[p] < min_started)
                min_started = started[p];
        end
        if (min_started >= N_PAGES / 2)
            half_age++;
        if (min_started == N_PAGES)
            full_age++;
        assert (!almost_full || min_started >= N_PAGES / 2)
            else log_error($sformatf("almost_full high with %0d packets", min_started));
        assert (almost_full || half_age <= 3)
            else log_error($sformatf("almost_full low with %0d packets", min_started));
        assert (!full || min_started == N_PAGES)
            else log_error($sformatf("full high with %0d packets", min_started));
        assert (full || full_age <= 3)
            else log_error("full low with every bank filled");
    endtask

    task automatic run_traffic(int limit);
        int cycles;
        cycles = 0;
        while (!traffic_done() && cycles < limit) begin
            @(negedge clk);
            drive_cycle();
            if (fill_phase)
                check_fill_flags();
            cycles++;
        end
        @(negedge clk);
        clear_inputs();
        assert (traffic_done()) else log_timeout("input traffic to be accepted");
    endtask

    // ----------------------------------------------------------------------
    // waits
    // ----------------------------------------------------------------------
    function automatic logic model_empty();
        logic empty;
        empty = (in_burst == '0);
        for (int i = 0; i < N_PORTS * N_PRIORS; i++) begin
            if (exp_lens[i].size() != 0)
                empty = 1'b0;
        end
        return empty;
    endfunction

    function automatic logic levels_at(logic level);
        if (level)
            return (&pause) && full && almost_full;
        return (pause == '0) && !full && !almost_full;
    endfunction

    task automatic wait_model_empty(int limit, string what);
        int cycles;
        cycles = 0;
        while (!model_empty() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (model_empty()) else log_timeout(what);
    endtask

    task automatic wait_levels(logic level, int limit, string what);
        int cycles;
        cycles = 0;
        while (!levels_at(level) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (levels_at(level)) else log_timeout(what);
    endtask

    task automatic hold_and_expect_quiet(int n);
        repeat (n) begin
            @(negedge clk);
            assert (rd_vld == '0) else log_error("output active while ready is low");
        end
    endtask

    // ----------------------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------------------
    task automatic compare_packet(int p);
        prior_t pr;
        int     idx;
        int     len;
        word_t  w;
        pr  = got_words[p][0][3:2];
        idx = p * N_PRIORS + int'(pr);
        assert (got_words[p][0][1:0] == port_idx_t'(p))
            else log_error($sformatf("port %0d got header %h", p, got_words[p][0]));
        assert (exp_lens[idx].size() != 0)
            else log_error($sformatf("port %0d sent an unexpected packet", p));
        if (exp_lens[idx].size() != 0) begin
            len = exp_lens[idx].pop_front();
            assert (got_count[p] == len)
                else log_error($sformatf("port %0d length %0d, expected %0d",
                                         p, got_count[p], len));
            for (int i = 0; i < len; i++) begin
                w = exp_words[idx].pop_front();
                if (i < got_count[p] && i < PAGE_WORDS) begin
                    assert (got_words[p][i] == w)
                        else log_error($sformatf("port %0d word %0d is %h, expected %h",
                                                 p, i, got_words[p][i], w));
                end
            end
        end
        if (p == 0)
            prior_log.push_back(pr);
    endtask

    task automatic check_port(int p);
        if (rd_vld[p]) begin
            if (rd_sop[p]) begin
                assert (!in_burst[p]) else log_error($sformatf("port %0d sop inside burst", p));
                in_burst[p]  = 1'b1;
                got_count[p] = 0;
            end else begin
                assert (in_burst[p]) else log_error($sformatf("port %0d word without sop", p));
            end
            if (got_count[p] < PAGE_WORDS)
                got_words[p][got_count[p]] = rd_data[p];
            got_count[p]++;
            if (rd_eop[p]) begin
                compare_packet(p);
                in_burst[p] = 1'b0;
            end
        end else begin
            assert (!in_burst[p]) else log_error($sformatf("port %0d rd_vld gap", p));
            assert (!rd_sop[p] && !rd_eop[p])
                else log_error($sformatf("port %0d sop or eop without rd_vld", p));
        end
    endtask

    // outputs are sampled mid cycle, away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < N_PORTS; p++)
                check_port(p);
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        seed       = 4;
        errors     = 0;
        timeouts   = 0;
        half_age   = 0;
        full_age   = 0;
        fill_phase = 1'b0;
        in_burst   = '0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        ready      = '0;
        clear_inputs();
        for (int p = 0; p < N_PORTS; p++) begin
            words_left[p] = 0;
            gap_left[p]   = 0;
            started[p]    = 0;
            sop_age[p]    = 0;
            got_count[p]  = 0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // idle outputs after reset
        assert (pause == '0 && !full && !almost_full) else log_error("flags high after reset");
        assert (rd_sop == '0 && rd_eop == '0 && rd_vld == '0)
            else log_error("read outputs active after reset");

        // random traffic with every output ready
        ready = '1;
        for (int p = 0; p < N_PORTS; p++) begin
            for (int k = 0; k < 40; k++)
                spec_q[p].push_back(random_spec());
        end
        run_traffic(20000);
        wait_model_empty(2000, "random traffic to drain");

        // one packet per priority toward port 0, released together
        ready = '0;
        for (int pr = 0; pr < N_PRIORS; pr++) begin
            pkt_spec_t s;
            s       = random_spec();
            s.dest  = '0;
            s.prior = prior_t'(pr);
            spec_q[0].push_back(s);
        end
        run_traffic(500);
        hold_and_expect_quiet(40);
        prior_log.delete();
        ready = 4'b0001;
        wait_model_empty(500, "priority packets on port 0");
        assert (prior_log.size() == N_PRIORS)
            else log_error($sformatf("port 0 sent %0d packets", prior_log.size()));
        for (int i = 0; i < prior_log.size(); i++) begin
            assert (int'(prior_log[i]) == N_PRIORS - 1 - i)
                else log_error($sformatf("packet %0d has priority %0d", i, prior_log[i]));
        end

        // fill every bank with outputs stalled, then drain
        ready = '0;
        half_age = 0;
        full_age = 0;
        for (int p = 0; p < N_PORTS; p++) begin
            started[p] = 0;
            sop_age[p] = 0;
            for (int k = 0; k < N_PAGES; k++)
                spec_q[p].push_back(random_spec());
        end
        fill_phase = 1'b1;
        run_traffic(2000);
        wait_levels(1'b1, 10, "pause, full and almost_full to rise");
        fill_phase = 1'b0;
        ready = '1;
        wait_model_empty(3000, "full buffer to drain");
        wait_levels(1'b0, 20, "pause, full and almost_full to fall");

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
